/* project.f */
+incdir+src
+incdir+testbench
src/rs_instr_pkg.sv
src/rs_sched_pkg.sv
src/rs_dispatch_in.sv
src/rs_entry_array.sv
src/rs_issue_select.sv
src/reservation_station.sv
testbench/rs_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module rs_tb -o rs_sim \
	&& ./obj_dir/rs_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log

grep -F -q "*** TEST FAILED ***" sim.log && exit 1 || exit 0

/* src/reservation_station.sv */
// reservation station top
// dispatch input, entry array and issue select joined into one
// out-of-order issue queue

`timescale 1ns/1ps
`default_nettype none

`include "rs_consts.svh"

module reservation_station
	import rs_instr_pkg::*, rs_sched_pkg::*;
(
	input  wire logic                            clock,
	input  wire logic                            reset,
	// dispatch side
	input  wire logic                            i_disp_valid,
	input  wire opcode_t                         i_disp_opcode,
	input  wire phys_tag_t                       i_disp_dest,
	input  wire phys_tag_t                       i_disp_src1,
	input  wire logic                            i_disp_src1_rdy,
	input  wire phys_tag_t                       i_disp_src2,
	input  wire logic                            i_disp_src2_rdy,
	output logic                                 o_disp_ready,
	// cdb broadcasts
	input  wire logic      [`RS_N_CDB-1:0]       i_cdb_valid,
	input  wire phys_tag_t [`RS_N_CDB-1:0]       i_cdb_tag,
	// issue side
	output logic                                 o_iss_valid,
	output opcode_t                              o_iss_opcode,
	output phys_tag_t                            o_iss_dest,
	output phys_tag_t                            o_iss_src1,
	output phys_tag_t                            o_iss_src2,
	input  wire logic                            i_iss_ready
);

	// dispatch to array
	logic                          wr_en;
	entry_idx_t                    wr_slot;
	opcode_t                       wr_opcode;
	phys_tag_t                     wr_dest, wr_src1, wr_src2;
	logic                          wr_src1_rdy, wr_src2_rdy;
	logic      [`RS_N_ENTRIES-1:0] free_mask;
	// array to issue select
	logic      [`RS_N_ENTRIES-1:0] ready_mask;
	age_t      [`RS_N_ENTRIES-1:0] age;
	opcode_t   [`RS_N_ENTRIES-1:0] opcode;
	phys_tag_t [`RS_N_ENTRIES-1:0] dest, src1, src2;
	logic                          take_en;
	entry_idx_t                    take_slot;

	rs_dispatch_in u_dispatch (
		.i_disp_valid, .i_disp_opcode, .i_disp_dest,
		.i_disp_src1, .i_disp_src1_rdy, .i_disp_src2, .i_disp_src2_rdy,
		.o_disp_ready, .i_cdb_valid, .i_cdb_tag, .i_free_mask(free_mask),
		.o_wr_en(wr_en), .o_wr_slot(wr_slot), .o_wr_opcode(wr_opcode),
		.o_wr_dest(wr_dest), .o_wr_src1(wr_src1), .o_wr_src2(wr_src2),
		.o_wr_src1_rdy(wr_src1_rdy), .o_wr_src2_rdy(wr_src2_rdy)
	);

	rs_entry_array u_array (
		.clock, .reset,
		.i_wr_en(wr_en), .i_wr_slot(wr_slot), .i_wr_opcode(wr_opcode),
		.i_wr_dest(wr_dest), .i_wr_src1(wr_src1), .i_wr_src2(wr_src2),
		.i_wr_src1_rdy(wr_src1_rdy), .i_wr_src2_rdy(wr_src2_rdy),
		.i_cdb_valid, .i_cdb_tag, .i_take_en(take_en), .i_take_slot(take_slot),
		.o_free_mask(free_mask), .o_ready_mask(ready_mask), .o_age(age),
		.o_opcode(opcode), .o_dest(dest), .o_src1(src1), .o_src2(src2)
	);

	rs_issue_select u_select (
		.clock, .reset,
		.i_ready_mask(ready_mask), .i_age(age), .i_opcode(opcode),
		.i_dest(dest), .i_src1(src1), .i_src2(src2),
		.o_take_en(take_en), .o_take_slot(take_slot),
		.o_iss_valid, .o_iss_opcode, .o_iss_dest, .o_iss_src1, .o_iss_src2,
		.i_iss_ready
	);

endmodule

`default_nettype wire

/* src/rs_consts.svh */
// reservation station constants
// sizes shared by the packages, the RTL and the testbench
// slot count must be a power of two, at least 4

`ifndef RS_CONSTS_SVH
`define RS_CONSTS_SVH

////////////////////////////////////////////////////////////
// station geometry
////////////////////////////////////////////////////////////

// number of station slots
`define RS_N_ENTRIES 8

////////////////////////////////////////////////////////////
// instruction fields
////////////////////////////////////////////////////////////

// physical register tag width
`define RS_TAG_BITS 6

// opcode field width
`define RS_OPCODE_BITS 7

// common data bus broadcast ports per cycle
`define RS_N_CDB 2

`endif

/* src/rs_dispatch_in.sv */
// reservation station dispatch input
// accepts one instruction per cycle into the lowest free slot,
// folding same-cycle cdb broadcasts into its source ready flags

`timescale 1ns/1ps
`default_nettype none

`include "rs_consts.svh"

module rs_dispatch_in
	import rs_instr_pkg::*, rs_sched_pkg::*;
(
	// dispatch side
	input  wire logic                            i_disp_valid,
	input  wire opcode_t                         i_disp_opcode,
	input  wire phys_tag_t                       i_disp_dest,
	input  wire phys_tag_t                       i_disp_src1,
	input  wire logic                            i_disp_src1_rdy,
	input  wire phys_tag_t                       i_disp_src2,
	input  wire logic                            i_disp_src2_rdy,
	output logic                                 o_disp_ready,
	// cdb broadcasts
	input  wire logic      [`RS_N_CDB-1:0]       i_cdb_valid,
	input  wire phys_tag_t [`RS_N_CDB-1:0]       i_cdb_tag,
	// slot occupancy from the entry array
	input  wire logic      [`RS_N_ENTRIES-1:0]   i_free_mask,
	// write port into the entry array
	output logic                                 o_wr_en,
	output entry_idx_t                           o_wr_slot,
	output opcode_t                              o_wr_opcode,
	output phys_tag_t                            o_wr_dest,
	output phys_tag_t                            o_wr_src1,
	output phys_tag_t                            o_wr_src2,
	output logic                                 o_wr_src1_rdy,
	output logic                                 o_wr_src2_rdy
);

	////////////////////////////////////////////////////////////
	// free slot search
	////////////////////////////////////////////////////////////

	// lowest free slot wins, scan from the top so it overwrites last
	always_comb begin
		o_wr_slot = '0;
		for (int i = `RS_N_ENTRIES - 1; i >= 0; i--) begin
			if (i_free_mask[i]) begin
				o_wr_slot = entry_idx_t'(i);
			end
		end
	end

	// room for one more
	assign o_disp_ready = |i_free_mask;
	assign o_wr_en      = i_disp_valid && o_disp_ready;

	////////////////////////////////////////////////////////////
	// operand bypass
	////////////////////////////////////////////////////////////

	// producer broadcasting this cycle would be missed by the array
	assign o_wr_src1_rdy = i_disp_src1_rdy || tag_on_cdb(i_disp_src1, i_cdb_valid, i_cdb_tag);
	assign o_wr_src2_rdy = i_disp_src2_rdy || tag_on_cdb(i_disp_src2, i_cdb_valid, i_cdb_tag);

	// payload goes straight through
	assign o_wr_opcode = i_disp_opcode;
	assign o_wr_dest   = i_disp_dest;
	assign o_wr_src1   = i_disp_src1;
	assign o_wr_src2   = i_disp_src2;

	// a write must never land on an occupied slot
	always_comb begin
		if (o_wr_en) begin
			assert final (i_free_mask[o_wr_slot])
				else $error("dispatch write to occupied slot %0d", o_wr_slot);
		end
	end

endmodule

`default_nettype wire

/* src/rs_entry_array.sv */
// reservation station entry array
// holds dispatched instructions, one state machine per slot,
// wakes operands on cdb tag matches and keeps a relative age
// for oldest-first selection

`timescale 1ns/1ps
`default_nettype none

`include "rs_consts.svh"

module rs_entry_array
	import rs_instr_pkg::*, rs_sched_pkg::*;
(
	input  wire logic                                clock,
	input  wire logic                                reset,
	// write port from dispatch
	input  wire logic                                i_wr_en,
	input  wire entry_idx_t                          i_wr_slot,
	input  wire opcode_t                             i_wr_opcode,
	input  wire phys_tag_t                           i_wr_dest,
	input  wire phys_tag_t                           i_wr_src1,
	input  wire phys_tag_t                           i_wr_src2,
	input  wire logic                                i_wr_src1_rdy,
	input  wire logic                                i_wr_src2_rdy,
	// cdb broadcasts
	input  wire logic      [`RS_N_CDB-1:0]           i_cdb_valid,
	input  wire phys_tag_t [`RS_N_CDB-1:0]           i_cdb_tag,
	// take port from issue select
	input  wire logic                                i_take_en,
	input  wire entry_idx_t                          i_take_slot,
	// per-slot view
	output logic       [`RS_N_ENTRIES-1:0]           o_free_mask,
	output logic       [`RS_N_ENTRIES-1:0]           o_ready_mask,
	output age_t       [`RS_N_ENTRIES-1:0]           o_age,
	output opcode_t    [`RS_N_ENTRIES-1:0]           o_opcode,
	output phys_tag_t  [`RS_N_ENTRIES-1:0]           o_dest,
	output phys_tag_t  [`RS_N_ENTRIES-1:0]           o_src1,
	output phys_tag_t  [`RS_N_ENTRIES-1:0]           o_src2
);

	entry_state_t state_q [`RS_N_ENTRIES];
	logic         src1_rdy_q [`RS_N_ENTRIES];
	logic         src2_rdy_q [`RS_N_ENTRIES];
	logic         wake1 [`RS_N_ENTRIES];
	logic         wake2 [`RS_N_ENTRIES];
	age_t         taken_age;

	////////////////////////////////////////////////////////////
	// wakeup
	////////////////////////////////////////////////////////////

	// flags as they will be after this cycle's broadcasts
	always_comb begin
		for (int i = 0; i < `RS_N_ENTRIES; i++) begin
			wake1[i] = src1_rdy_q[i] || tag_on_cdb(o_src1[i], i_cdb_valid, i_cdb_tag);
			wake2[i] = src2_rdy_q[i] || tag_on_cdb(o_src2[i], i_cdb_valid, i_cdb_tag);
		end
	end

	// age of the slot leaving this cycle
	assign taken_age = o_age[i_take_slot];

	////////////////////////////////////////////////////////////
	// slot state and age
	////////////////////////////////////////////////////////////

	// age counts younger occupied slots, so it stays unique:
	// every write steps it up, a take of a younger slot steps it down
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RS_N_ENTRIES; i++) begin
				state_q[i]    <= es_free;
				src1_rdy_q[i] <= 1'b0;
				src2_rdy_q[i] <= 1'b0;
				o_age[i]      <= '0;
			end
		end else begin
			for (int i = 0; i < `RS_N_ENTRIES; i++) begin
				case (state_q[i])
					es_free: begin
						if (i_wr_en && (i_wr_slot == entry_idx_t'(i))) begin
							src1_rdy_q[i] <= i_wr_src1_rdy;
							src2_rdy_q[i] <= i_wr_src2_rdy;
							o_age[i]      <= '0;
							state_q[i]    <= (i_wr_src1_rdy && i_wr_src2_rdy) ? es_ready : es_waiting;
						end
					end
					es_waiting: begin
						src1_rdy_q[i] <= wake1[i];
						src2_rdy_q[i] <= wake2[i];
						if (wake1[i] && wake2[i]) begin
							state_q[i] <= es_ready;
						end
					end
					es_ready: begin
						if (i_take_en && (i_take_slot == entry_idx_t'(i))) begin
							state_q[i] <= es_free;
						end
					end
					default: state_q[i] <= es_free;
				endcase
				// occupied slots age, saturating at the top
				if (state_q[i] != es_free) begin
					if (i_wr_en && !(i_take_en && (o_age[i] > taken_age))) begin
						if (o_age[i] != '1) begin
							o_age[i] <= o_age[i] + 1'b1;
						end
					end else if (!i_wr_en && i_take_en && (o_age[i] > taken_age)) begin
						o_age[i] <= o_age[i] - 1'b1;
					end
				end
			end
		end
	end

	// instruction payload
	always_ff @(posedge clock) begin
		if (i_wr_en) begin
			o_opcode[i_wr_slot] <= i_wr_opcode;
			o_dest[i_wr_slot]   <= i_wr_dest;
			o_src1[i_wr_slot]   <= i_wr_src1;
			o_src2[i_wr_slot]   <= i_wr_src2;
		end
	end

	always_comb begin
		for (int i = 0; i < `RS_N_ENTRIES; i++) begin
			o_free_mask[i]  = (state_q[i] == es_free);
			o_ready_mask[i] = (state_q[i] == es_ready);
		end
	end

	// take must come from a slot that is ready now
	assert property (@(posedge clock) disable iff (reset)
		i_take_en |-> (state_q[i_take_slot] == es_ready))
		else $error("take of slot %0d which is not ready", i_take_slot);

	// dispatch and issue never meet on one slot
	assert property (@(posedge clock) disable iff (reset)
		(i_wr_en && i_take_en) |-> (i_wr_slot != i_take_slot))
		else $error("write and take both hit slot %0d", i_wr_slot);

endmodule

`default_nettype wire

/* src/rs_instr_pkg.sv */
// instruction types
// fields of an instruction as it moves from dispatch to issue,
// plus the common data bus tag match used for wakeup

`default_nettype none

`include "rs_consts.svh"

package rs_instr_pkg;

	// physical register tag
	typedef logic [`RS_TAG_BITS-1:0] phys_tag_t;

	// instruction opcode
	typedef logic [`RS_OPCODE_BITS-1:0] opcode_t;

	// true when any valid cdb port carries this tag
	function automatic logic tag_on_cdb(
		input phys_tag_t                  tag,
		input logic      [`RS_N_CDB-1:0] cdb_valid,
		input phys_tag_t [`RS_N_CDB-1:0] cdb_tag
	);
		logic hit;
		hit = 1'b0;
		for (int p = 0; p < `RS_N_CDB; p++) begin
			if (cdb_valid[p] && (cdb_tag[p] == tag)) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

endpackage

`default_nettype wire

/* src/rs_issue_select.sv */
// reservation station issue select
// picks the oldest ready slot and moves it into a one-entry
// issue register with valid/ready back-pressure

`timescale 1ns/1ps
`default_nettype none

`include "rs_consts.svh"

module rs_issue_select
	import rs_instr_pkg::*, rs_sched_pkg::*;
(
	input  wire logic                               clock,
	input  wire logic                               reset,
	// per-slot view of the entry array
	input  wire logic      [`RS_N_ENTRIES-1:0]      i_ready_mask,
	input  wire age_t      [`RS_N_ENTRIES-1:0]      i_age,
	input  wire opcode_t   [`RS_N_ENTRIES-1:0]      i_opcode,
	input  wire phys_tag_t [`RS_N_ENTRIES-1:0]      i_dest,
	input  wire phys_tag_t [`RS_N_ENTRIES-1:0]      i_src1,
	input  wire phys_tag_t [`RS_N_ENTRIES-1:0]      i_src2,
	// take port back to the array
	output logic                                    o_take_en,
	output entry_idx_t                              o_take_slot,
	// issue side
	output logic                                    o_iss_valid,
	output opcode_t                                 o_iss_opcode,
	output phys_tag_t                               o_iss_dest,
	output phys_tag_t                               o_iss_src1,
	output phys_tag_t                               o_iss_src2,
	input  wire logic                               i_iss_ready
);

	localparam int N = `RS_N_ENTRIES;

	// heap-ordered tree, leaves at N..2N-1, root at 1
	logic       node_vld [1:2*N-1];
	age_t       node_age [1:2*N-1];
	entry_idx_t node_idx [1:2*N-1];
	logic       load_en;

	////////////////////////////////////////////////////////////
	// oldest-ready reduction
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < N; i++) begin
			node_vld[N+i] = i_ready_mask[i];
			node_age[N+i] = i_age[i];
			node_idx[N+i] = entry_idx_t'(i);
		end
		// right child only wins when strictly older
		for (int n = N - 1; n >= 1; n--) begin
			if (node_vld[2*n+1] && (!node_vld[2*n] || (node_age[2*n+1] > node_age[2*n]))) begin
				node_vld[n] = 1'b1;
				node_age[n] = node_age[2*n+1];
				node_idx[n] = node_idx[2*n+1];
			end else begin
				node_vld[n] = node_vld[2*n];
				node_age[n] = node_age[2*n];
				node_idx[n] = node_idx[2*n];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// issue register
	////////////////////////////////////////////////////////////

	// empty or draining this cycle
	assign load_en     = !o_iss_valid || i_iss_ready;
	assign o_take_en   = load_en && node_vld[1];
	assign o_take_slot = node_idx[1];

	always_ff @(posedge clock) begin
		if (reset) begin
			o_iss_valid <= 1'b0;
		end else if (load_en) begin
			o_iss_valid <= node_vld[1];
		end
	end

	always_ff @(posedge clock) begin
		if (o_take_en) begin
			o_iss_opcode <= i_opcode[node_idx[1]];
			o_iss_dest   <= i_dest[node_idx[1]];
			o_iss_src1   <= i_src1[node_idx[1]];
			o_iss_src2   <= i_src2[node_idx[1]];
		end
	end

	// stalled issue keeps its whole payload
	assert property (@(posedge clock) disable iff (reset)
		(o_iss_valid && !i_iss_ready) |=> (o_iss_valid && $stable(o_iss_opcode)
			&& $stable(o_iss_dest) && $stable(o_iss_src1) && $stable(o_iss_src2)))
		else $error("issue outputs changed while stalled");

endmodule

`default_nettype wire

/* src/rs_sched_pkg.sv */
// scheduler bookkeeping types
// slot index, relative age and per-slot state of the station

`default_nettype none

`include "rs_consts.svh"

package rs_sched_pkg;

	////////////////////////////////////////////////////////////
	// slot addressing
	////////////////////////////////////////////////////////////

	// index of one station slot
	typedef logic [$clog2(`RS_N_ENTRIES)-1:0] entry_idx_t;

	// age of an occupied slot, larger is older
	// same width as the index, so one slot per value
	typedef logic [$clog2(`RS_N_ENTRIES)-1:0] age_t;

	////////////////////////////////////////////////////////////
	// slot state
	////////////////////////////////////////////////////////////

	// free -> waiting on operands -> ready to issue -> free
	typedef enum logic [1:0] {
		es_free,
		es_waiting,
		es_ready
	} entry_state_t;

endpackage

`default_nettype wire

/* testbench/rs_tb_table.svh */
// reservation station test table
// one add_row call per dispatched instruction, applied in order
// columns: test, opcode, dest, src1, src1 ready, src2, src2 ready,
//   idle cycles after, cdb valid mask, cdb tag 0, cdb tag 1,
//   cdb with the dispatch (1) or the cycle after (0), issue ready pattern
// issue ready pattern: 0 high, 1 low, 2 random, 3 low and station full

// in-order issue, all operands ready
add_row(2, 'h01, 10,  1, 1,  2, 1, 0, 2'b00,  0,  0, 0, 0);
add_row(2, 'h02, 11,  3, 1,  4, 1, 0, 2'b00,  0,  0, 0, 0);
add_row(2, 'h03, 12,  5, 1,  6, 1, 0, 2'b00,  0,  0, 0, 0);
add_row(2, 'h04, 13,  7, 1,  8, 1, 2, 2'b00,  0,  0, 0, 0);

// waiters on tags 40 and 41, overtaken by younger ready work
// consumer stalls around the first wakeup, so each woken waiter
// meets younger entries that were ready before it
add_row(3, 'h10, 20, 40, 0,  2, 1, 0, 2'b00,  0,  0, 0, 0);
add_row(3, 'h11, 21,  3, 1,  4, 1, 0, 2'b00,  0,  0, 0, 0);
add_row(3, 'h12, 22,  5, 1, 41, 0, 2, 2'b00,  0,  0, 0, 1);
add_row(3, 'h13, 23,  6, 1,  7, 1, 2, 2'b10,  0, 40, 0, 1);
add_row(3, 'h14, 24,  8, 1,  9, 1, 0, 2'b00,  0,  0, 0, 0);
add_row(3, 'h15, 25, 10, 1, 11, 1, 1, 2'b01, 41,  0, 0, 0);
add_row(3, 'h16, 26, 12, 1, 13, 1, 2, 2'b00,  0,  0, 0, 0);

// producer broadcasts in the dispatch cycle itself
add_row(4, 'h20, 30, 42, 0, 43, 0, 2, 2'b11, 42, 43, 1, 0);
add_row(4, 'h21, 31, 12, 1, 44, 0, 2, 2'b10,  0, 44, 1, 0);

// fill slots and issue register with the consumer stalled
add_row(5, 'h30, 32,  1, 1,  2, 1, 0, 2'b00,  0,  0, 0, 1);
add_row(5, 'h31, 33,  3, 1,  4, 1, 0, 2'b00,  0,  0, 0, 1);
add_row(5, 'h32, 34,  5, 1,  6, 1, 0, 2'b00,  0,  0, 0, 1);
add_row(5, 'h33, 35,  7, 1,  8, 1, 0, 2'b00,  0,  0, 0, 1);
add_row(5, 'h34, 36,  9, 1, 10, 1, 0, 2'b00,  0,  0, 0, 1);
add_row(5, 'h35, 37, 11, 1, 12, 1, 0, 2'b00,  0,  0, 0, 1);
add_row(5, 'h36, 38, 13, 1, 14, 1, 0, 2'b00,  0,  0, 0, 1);
add_row(5, 'h37, 39, 15, 1, 16, 1, 0, 2'b00,  0,  0, 0, 1);
add_row(5, 'h38, 47, 17, 1, 18, 1, 1, 2'b00,  0,  0, 0, 3);

// random consumer gaps, some late wakeups
add_row(6, 'h40, 48,  1, 1,  2, 1, 0, 2'b00,  0,  0, 0, 2);
add_row(6, 'h41, 49, 50, 0,  3, 1, 1, 2'b00,  0,  0, 0, 2);
add_row(6, 'h42, 52,  4, 1, 51, 0, 0, 2'b00,  0,  0, 0, 2);
add_row(6, 'h43, 53,  5, 1,  6, 1, 2, 2'b01, 51,  0, 0, 2);
add_row(6, 'h44, 54,  7, 1,  8, 1, 1, 2'b10,  0, 50, 0, 2);
add_row(6, 'h45, 55,  9, 1, 10, 1, 3, 2'b00,  0,  0, 0, 2);

/* testbench/rs_tb.sv */
// reservation station testbench
// table-driven dispatch with a cycle model of slots and issue register

`timescale 1ns/1ps
`default_nettype none

`include "rs_consts.svh"

module rs_tb
	import rs_instr_pkg::*;
();

	localparam int SEED          = 32'hcfd4_60a1;
	localparam int CLK_PERIOD    = 10;
	localparam int RESET_CYCLES  = 8;
	localparam int DISP_TIMEOUT  = 50;
	localparam int DRAIN_TIMEOUT = 200;
	localparam int N             = `RS_N_ENTRIES;

	typedef struct {
		int       test;
		int       op;
		int       dest;
		int       s1;
		bit       r1;
		int       s2;
		bit       r2;
		int       wait_n;
		bit [1:0] mask;
		int       tag0;
		int       tag1;
		bit       same;
		int       pattern;
	} row_t;

	logic clock, reset;
	logic disp_valid, disp_src1_rdy, disp_src2_rdy, disp_ready;
	opcode_t disp_opcode, iss_opcode;
	phys_tag_t disp_dest, disp_src1, disp_src2;
	logic [`RS_N_CDB-1:0] cdb_valid;
	phys_tag_t [`RS_N_CDB-1:0] cdb_tag;
	logic iss_valid, iss_ready;
	phys_tag_t iss_dest, iss_src1, iss_src2;

	row_t rows[$];
	// model of occupied slots, oldest first
	opcode_t   q_op[$];
	phys_tag_t q_dest[$], q_s1[$], q_s2[$];
	bit        q_r1[$], q_r2[$], q_rdy[$];
	// model of the issue register
	bit        m_valid;
	opcode_t   m_op;
	phys_tag_t m_dest, m_s1, m_s2;
	int errors, test_errors, issued, tests_run, tests_failed;
	bit timed_out, last_accept;

	reservation_station dut0 (
		.clock, .reset,
		.i_disp_valid(disp_valid), .i_disp_opcode(disp_opcode), .i_disp_dest(disp_dest),
		.i_disp_src1(disp_src1), .i_disp_src1_rdy(disp_src1_rdy),
		.i_disp_src2(disp_src2), .i_disp_src2_rdy(disp_src2_rdy), .o_disp_ready(disp_ready),
		.i_cdb_valid(cdb_valid), .i_cdb_tag(cdb_tag),
		.o_iss_valid(iss_valid), .o_iss_opcode(iss_opcode), .o_iss_dest(iss_dest),
		.o_iss_src1(iss_src1), .o_iss_src2(iss_src2), .i_iss_ready(iss_ready)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// table and model
	////////////////////////////////////////////////////////////

	function automatic void add_row(int test, int op, int dest, int s1, bit r1,
		int s2, bit r2, int wait_n, bit [1:0] mask, int tag0, int tag1, bit same,
		int pattern);
		row_t r;
		r = '{test, op, dest, s1, r1, s2, r2, wait_n, mask, tag0, tag1, same, pattern};
		rows.push_back(r);
	endfunction

	task automatic load_table();
		`include "rs_tb_table.svh"
	endtask

	function automatic bit cdb_hit(phys_tag_t tag);
		bit hit;
		hit = 1'b0;
		for (int p = 0; p < `RS_N_CDB; p++) begin
			if (cdb_valid[p] && (cdb_tag[p] == tag)) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	// what the coming rising edge does, from the driven inputs
	function automatic void model_step();
		int sel;
		sel = -1;
		last_accept = disp_valid && (q_op.size() < N);
		// register loads when empty or draining, oldest ready first
		if (!m_valid || iss_ready) begin
			if (m_valid) begin
				issued++;
			end
			for (int i = 0; i < q_op.size(); i++) begin
				if (q_rdy[i] && sel < 0) begin
					sel = i;
				end
			end
			m_valid = (sel >= 0);
			if (sel >= 0) begin
				m_op   = q_op[sel];
				m_dest = q_dest[sel];
				m_s1   = q_s1[sel];
				m_s2   = q_s2[sel];
				q_op.delete(sel);
				q_dest.delete(sel);
				q_s1.delete(sel);
				q_s2.delete(sel);
				q_r1.delete(sel);
				q_r2.delete(sel);
				q_rdy.delete(sel);
			end
		end
		// wakeup of waiting entries
		for (int i = 0; i < q_op.size(); i++) begin
			if (!q_rdy[i]) begin
				q_r1[i]  = q_r1[i] || cdb_hit(q_s1[i]);
				q_r2[i]  = q_r2[i] || cdb_hit(q_s2[i]);
				q_rdy[i] = q_r1[i] && q_r2[i];
			end
		end
		// newcomer, with same-cycle bypass
		if (last_accept) begin
			q_op.push_back(disp_opcode);
			q_dest.push_back(disp_dest);
			q_s1.push_back(disp_src1);
			q_s2.push_back(disp_src2);
			q_r1.push_back(disp_src1_rdy || cdb_hit(disp_src1));
			q_r2.push_back(disp_src2_rdy || cdb_hit(disp_src2));
			q_rdy.push_back(q_r1[$] && q_r2[$]);
		end
	endfunction

	////////////////////////////////////////////////////////////
	// driver tasks
	////////////////////////////////////////////////////////////

	function automatic void report_error(string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		errors++;
		test_errors++;
	endfunction

	function automatic void drive_ready(int pattern);
		if (pattern == 2) begin
			iss_ready = (($urandom % 3) != 0);
		end else begin
			iss_ready = (pattern == 0);
		end
	endfunction

	// one clock, then compare the DUT against the model
	task automatic cycle();
		bit hold;
		opcode_t h_op;
		phys_tag_t h_dest, h_s1, h_s2;
		hold   = iss_valid && !iss_ready;
		h_op   = iss_opcode;
		h_dest = iss_dest;
		h_s1   = iss_src1;
		h_s2   = iss_src2;
		model_step();
		@(negedge clock);
		if (hold && (iss_opcode !== h_op || iss_dest !== h_dest || iss_src1 !== h_s1
			|| iss_src2 !== h_s2)) begin
			report_error("issue outputs changed while stalled");
		end
		if (iss_valid !== m_valid) begin
			report_error($sformatf("o_iss_valid is %b, expected %b", iss_valid, m_valid));
		end else if (m_valid && (iss_opcode !== m_op || iss_dest !== m_dest
			|| iss_src1 !== m_s1 || iss_src2 !== m_s2)) begin
			report_error($sformatf("issued op %h dest %0d src %0d %0d, expected %h %0d %0d %0d",
				iss_opcode, iss_dest, iss_src1, iss_src2, m_op, m_dest, m_s1, m_s2));
		end
		if (disp_ready !== (q_op.size() < N)) begin
			report_error($sformatf("o_disp_ready is %b with %0d slots used", disp_ready,
				q_op.size()));
		end
	endtask

	task automatic apply_row(row_t r);
		int k;
		disp_opcode   = opcode_t'(r.op);
		disp_dest     = phys_tag_t'(r.dest);
		disp_src1     = phys_tag_t'(r.s1);
		disp_src2     = phys_tag_t'(r.s2);
		disp_src1_rdy = r.r1;
		disp_src2_rdy = r.r2;
		disp_valid    = 1'b1;
		cdb_tag[0]    = phys_tag_t'(r.tag0);
		cdb_tag[1]    = phys_tag_t'(r.tag1);
		cdb_valid     = r.same ? r.mask : '0;
		last_accept   = 1'b0;
		for (k = 0; k < DISP_TIMEOUT && !last_accept; k++) begin
			drive_ready(r.pattern);
			cycle();
		end
		if (!last_accept) begin
			$display("timeout: a dispatch in test %0d was never accepted", r.test);
			timed_out = 1'b1;
			errors++;
			test_errors++;
		end
		disp_valid = 1'b0;
		cdb_valid  = '0;
		// broadcast one cycle after the dispatch
		if (!r.same && r.mask != 2'b00) begin
			cdb_valid = r.mask;
			drive_ready(r.pattern);
			cycle();
			cdb_valid = '0;
		end
		repeat (r.wait_n) begin
			drive_ready(r.pattern);
			cycle();
		end
		if (r.pattern == 3 && disp_ready !== 1'b0) begin
			report_error("o_disp_ready still high with slots and issue register full");
		end
	endtask

	task automatic drain();
		int k;
		disp_valid = 1'b0;
		iss_ready  = 1'b1;
		for (k = 0; k < DRAIN_TIMEOUT && (m_valid || q_op.size() != 0); k++) begin
			cycle();
		end
		if (m_valid || q_op.size() != 0) begin
			$display("timeout: the station did not drain, %0d entries left", q_op.size());
			timed_out = 1'b1;
			errors++;
			test_errors++;
		end
	endtask

	function automatic void end_test(int num);
		$display("test %0d %s, %0d issued, %0d errors", num,
			(test_errors == 0) ? "ok" : "FAILED", issued, test_errors);
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
		end
		test_errors = 0;
		issued      = 0;
	endfunction

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int cur;
		void'($urandom(SEED));
		reset         = 1'b1;
		disp_valid    = 1'b0;
		disp_opcode   = '0;
		disp_dest     = '0;
		disp_src1     = '0;
		disp_src2     = '0;
		disp_src1_rdy = 1'b0;
		disp_src2_rdy = 1'b0;
		cdb_valid     = '0;
		cdb_tag       = '0;
		iss_ready     = 1'b1;
		m_valid       = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		// state right after reset
		if (iss_valid !== 1'b0) begin
			report_error("o_iss_valid high after reset");
		end
		if (disp_ready !== 1'b1) begin
			report_error("o_disp_ready low after reset");
		end
		end_test(1);
		load_table();
		cur = rows[0].test;
		for (int i = 0; i < rows.size() && !timed_out; i++) begin
			if (rows[i].test != cur) begin
				drain();
				end_test(cur);
				cur = rows[i].test;
			end
			apply_row(rows[i]);
		end
		if (!timed_out) begin
			drain();
		end
		end_test(cur);
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
